//--- common/cpu_mem_pkg.sv
`default_nettype none

// Widths and timing of the shared instruction memory as the fetch side sees it
package cpu_mem_pkg;

	localparam int ADDRESS_BITS = 15; // Word address, so 32K instructions
	localparam int DATA_BITS = 16; // One instruction per memory word

	typedef logic [ADDRESS_BITS-1:0] mem_address_t;
	typedef logic [DATA_BITS-1:0] mem_data_t;

	// Cycles from the cycle a request is taken to the cycle its success
	// pulse and data show up on the read port
	localparam int READ_LATENCY = 2;

endpackage

`default_nettype wire

//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// The tag holds the whole word address, index bits included
	typedef cpu_mem_pkg::mem_address_t line_tag_t;

	// One cache line packed into a single block-RAM word
	typedef struct packed {
		line_tag_t tag; // Address the line was filled from
		logic invalid; // Set by the sweep, cleared by a fill
		cpu_mem_pkg::mem_data_t instruction;
	} cache_line_t;

	localparam int LINE_BITS = $bits(cache_line_t); // 32 with the widths above

	localparam int DEFAULT_DEPTH_BITS = 8; // 256 lines

	// Builds a line from its three fields
	function automatic cache_line_t make_line(input line_tag_t tag, input logic invalid,
		input cpu_mem_pkg::mem_data_t instruction);
		cache_line_t line;
		line.tag = tag;
		line.invalid = invalid;
		line.instruction = instruction;
		return line;
	endfunction

endpackage

`default_nettype wire

//--- common/mem_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Read channel between the instruction cache and the arbitrated memory
interface mem_rd_if;
	import cpu_mem_pkg::*;

	logic rd_req; // Cache wants the word at address
	mem_address_t address;
	logic success; // One cycle pulse, READ_LATENCY after the request was taken
	mem_address_t returned_address; // Address the data belongs to
	mem_data_t data;

	modport cache (
		output rd_req,
		output address,
		input success,
		input returned_address,
		input data
	);

	modport memory (
		input rd_req,
		input address,
		output success,
		output returned_address,
		output data
	);

endinterface

`default_nettype wire

//--- icache/bram.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port block RAM, one read port and one write port on the same clock
module bram #(
	parameter int BITS = 32,
	parameter int ADDRESS_BITS = 8
) (
	input logic CLK,
	input logic [ADDRESS_BITS-1:0] rd_address,
	output logic [BITS-1:0] data_out,
	input logic [ADDRESS_BITS-1:0] wr_address,
	input logic [BITS-1:0] data_in,
	input logic wr
);

	logic [BITS-1:0] mem_array [1 << ADDRESS_BITS]; // Block RAM has no reset

	// Registered read, so data_out follows rd_address by one cycle
	always_ff @(posedge CLK) begin
		data_out <= mem_array[rd_address]; // Old contents when the write hits the same word
	end

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem_array[wr_address] <= data_in;
		end
	end

endmodule

`default_nettype wire

//--- icache/cpu_instruction_cache.sv
`timescale 1ns/1ps
`default_nettype none

// Direct-mapped instruction cache with fill, prefetch and an invalidation sweep
module cpu_instruction_cache #(
	parameter int CACHE_DEPTH_BITS = icache_pkg::DEFAULT_DEPTH_BITS
) (
	input logic CLK,
	input logic RSTb,
	input cpu_mem_pkg::mem_address_t request_address, // Held by the CPU until the miss clears
	output cpu_mem_pkg::mem_data_t instruction,
	output logic cache_miss,
	input logic invalidate_cache,
	output logic invalidation_done,
	mem_rd_if.cache mem
);
	import cpu_mem_pkg::*;
	import icache_pkg::*;

	typedef logic [CACHE_DEPTH_BITS-1:0] index_t;
	typedef enum logic [1:0] {ST_SWEEP, ST_DONE, ST_RUN} state_t;

	localparam index_t LAST_INDEX = '1;

	state_t state;
	index_t sweep_index; // Line being invalidated
	mem_address_t address_q; // Request address lined up with the BRAM output
	mem_address_t address_qq; // Previous value, to spot a new request
	mem_address_t fill_ptr; // Next address offered to memory
	logic fill_active;
	cache_line_t line_out;
	cache_line_t line_in;
	index_t wr_index;
	logic wr_en;

	bram #(
		.BITS(LINE_BITS),
		.ADDRESS_BITS(CACHE_DEPTH_BITS)
	) u_bram (
		.CLK(CLK),
		.rd_address(request_address[CACHE_DEPTH_BITS-1:0]),
		.data_out(line_out),
		.wr_address(wr_index),
		.data_in(line_in),
		.wr(wr_en)
	);

	// The line is only good when its tag is the full registered address
	// and the sweep has not marked it; while sweeping every fetch misses
	assign cache_miss = (state != ST_RUN) || line_out.invalid || (line_out.tag != address_q);
	assign instruction = line_out.instruction;
	assign invalidation_done = (state == ST_DONE); // One cycle, the FSM never stays there

	assign mem.rd_req = fill_active; // Cleared on the edge that starts a sweep
	assign mem.address = fill_ptr;

	// The sweep owns the write port; otherwise returning words are written
	always_comb begin
		if (state == ST_SWEEP) begin
			wr_en = 1'b1;
			wr_index = sweep_index;
			line_in = make_line('0, 1'b1, '0);
		end else begin
			wr_en = (state == ST_RUN) && mem.success; // Successes outside RUN are dropped
			wr_index = mem.returned_address[CACHE_DEPTH_BITS-1:0];
			line_in = make_line(mem.returned_address, 1'b0, mem.data);
		end
	end

	// Sweep FSM, also started by reset since the RAM powers up with junk
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= ST_SWEEP;
			sweep_index <= '0;
		end else begin
			case (state)
				ST_SWEEP: begin
					sweep_index <= sweep_index + 1'b1; // Wraps back to 0 after the last line
					if (sweep_index == LAST_INDEX)
						state <= ST_DONE;
				end
				ST_DONE: state <= ST_RUN;
				ST_RUN: begin
					if (invalidate_cache) begin
						state <= ST_SWEEP;
						sweep_index <= '0;
					end
				end
				default: state <= ST_SWEEP;
			endcase
		end
	end

	// Fill pointer. A fresh miss restarts it at the missing address. A miss
	// that is still there once the pointer has run out also restarts it, which
	// covers requests the arbiter refused, as only returned words are written
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			address_q <= '0;
			address_qq <= '0;
			fill_active <= 1'b0;
		end else begin
			address_q <= request_address;
			address_qq <= address_q;
			if ((state != ST_RUN) || invalidate_cache) begin
				fill_active <= 1'b0; // Nothing is offered while the lines are being wiped
			end else if (cache_miss && ((address_q != address_qq) || !fill_active)) begin
				fill_ptr <= address_q;
				fill_active <= 1'b1;
			end else if (fill_active) begin
				// Prefetch up to the last index to keep the memory pipeline busy
				if (fill_ptr[CACHE_DEPTH_BITS-1:0] == LAST_INDEX)
					fill_active <= 1'b0;
				else
					fill_ptr <= fill_ptr + 1'b1;
			end
		end
	end

	// The read port stays quiet for the whole sweep
	assert property (@(posedge CLK) disable iff (!RSTb)
		(state == ST_SWEEP) |-> !mem.rd_req);

	assert property (@(posedge CLK) disable iff (!RSTb)
		invalidation_done |=> !invalidation_done);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_fetch_subsystem -Mdir obj_dir -o tb_fetch_subsystem \
	-f verilog.f > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_fetch_subsystem > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -qx "all tests passed" "$SIM_LOG" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/tb_fetch_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the fetch side: 16-line cache in front of the arbitrated memory
module tb_fetch_subsystem;
	import cpu_mem_pkg::*;

	localparam int DEPTH_BITS = 4; // Short sweeps, 16 lines
	localparam int RESET_CYCLES = 8;
	localparam int LOADED_WORDS = 1024; // Only this low part of memory is loaded and fetched
	localparam int MAX_WAIT = 500; // Cycles allowed for any single wait
	localparam int RANDOM_FETCHES = 300;
	localparam mem_address_t ADDRESS_MASK = mem_address_t'(LOADED_WORDS - 1);
	localparam mem_address_t BASE_ADDRESS = 15'h100; // Index 0 of its block
	localparam mem_address_t ALIAS_ADDRESS = 15'h200; // Same index, other tag
	localparam mem_address_t CHANGED_ADDRESS = 15'h105;

	logic CLK;
	logic RSTb;
	mem_address_t fetch_address;
	mem_data_t instruction;
	logic fetch_miss;
	logic invalidate;
	logic invalidation_done;
	logic mem_busy;
	logic load_en;
	mem_address_t load_address;
	mem_data_t load_data;

	integer seed;
	integer rand_word;
	logic random_busy; // Lets the hit loop toggle mem_busy every cycle
	mem_data_t model_mem [1 << ADDRESS_BITS]; // What memory should hold, word by word

	fetch_subsystem_top #(
		.CACHE_DEPTH_BITS(DEPTH_BITS)
	) u_dut (
		.CLK(CLK),
		.RSTb(RSTb),
		.fetch_address(fetch_address),
		.instruction(instruction),
		.fetch_miss(fetch_miss),
		.invalidate(invalidate),
		.invalidation_done(invalidation_done),
		.mem_busy(mem_busy),
		.load_en(load_en),
		.load_address(load_address),
		.load_data(load_data)
	);

	always #10 CLK = ~CLK;

	// A hit must carry the word loaded at the address presented one cycle before
	assert property (@(posedge CLK) disable iff (!RSTb)
		!fetch_miss |-> (instruction == model_mem[$past(fetch_address)]))
	else begin
		$display("MISMATCH at %0t: hit returned a word that memory does not hold", $time);
		$display("tests failed");
		$fatal(1);
	end

	// The sweep's done cycle is still outside normal running, so nothing may hit
	assert property (@(posedge CLK) disable iff (!RSTb) invalidation_done |-> fetch_miss)
	else begin
		$display("MISMATCH at %0t: fetch hit while invalidation_done was high", $time);
		$display("tests failed");
		$fatal(1);
	end

	// Writes the whole model image through the load port, one word per cycle
	task automatic load_memory();
		for (int i = 0; i < LOADED_WORDS; i++) begin
			@(negedge CLK);
			load_en = 1'b1;
			load_address = mem_address_t'(i);
			load_data = model_mem[i];
		end
		@(negedge CLK);
		load_en = 1'b0;
	endtask

	task automatic change_word(input mem_address_t address, input mem_data_t word);
		@(negedge CLK);
		load_en = 1'b1;
		load_address = address;
		load_data = word;
		model_mem[address] = word; // Memory takes it on the coming edge
		@(negedge CLK);
		load_en = 1'b0;
	endtask

	task automatic await_invalidation();
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < MAX_WAIT) begin
			@(negedge CLK);
			seen = invalidation_done;
			cycles++;
		end
		if (!seen) begin
			$display("Timed out waiting for the invalidation sweep to finish");
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Holds the current address until fetch_miss drops
	task automatic hold_until_hit();
		int cycles;
		logic hit;
		cycles = 0;
		hit = 1'b0;
		while (!hit && cycles < MAX_WAIT) begin
			@(negedge CLK);
			if (random_busy)
				mem_busy = (($random(seed) & 7) < 3); // Busy about three cycles in eight
			hit = !fetch_miss;
			cycles++;
		end
		if (!hit) begin
			$display("Timed out waiting for the fetch of address %h to hit", fetch_address);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic fetch_and_expect_miss(input mem_address_t address);
		fetch_address = address;
		@(negedge CLK);
		assert (fetch_miss) else begin
			$display("MISMATCH at %0t: fetch of %h hit but should miss", $time, address);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	initial begin
		seed = 25730;
		CLK = 1'b0;
		RSTb = 1'b0;
		fetch_address = '0;
		invalidate = 1'b0;
		mem_busy = 1'b1; // Nothing is served until memory is loaded
		load_en = 1'b0;
		load_address = '0;
		load_data = '0;
		random_busy = 1'b0;
		for (int i = 0; i < LOADED_WORDS; i++)
			model_mem[i] = mem_data_t'($random(seed));

		repeat (RESET_CYCLES) @(negedge CLK);
		assert (fetch_miss && !invalidation_done) else begin
			$display("MISMATCH at %0t: fetch_miss low or done high during reset", $time);
			$display("tests failed");
			$fatal(1);
		end
		RSTb = 1'b1;

		// Reset sweep, then the freshly wiped cache must miss everywhere
		await_invalidation();
		load_memory();
		fetch_and_expect_miss(15'h000);
		fetch_and_expect_miss(15'h123);
		fetch_and_expect_miss(15'h3ff);

		// First fill at index 0
		mem_busy = 1'b0;
		fetch_and_expect_miss(BASE_ADDRESS);
		hold_until_hit();

		// The rest of the block comes in by prefetch and then stays put
		for (int a = 1; a < (1 << DEPTH_BITS); a++) begin
			fetch_address = BASE_ADDRESS + mem_address_t'(a);
			@(negedge CLK);
			// Prefetch streams one word per cycle, so each line is in by the time it is fetched
			assert (!fetch_miss) else begin
				$display("MISMATCH at %0t: line %h was not prefetched", $time, fetch_address);
				$display("tests failed");
				$fatal(1);
			end
		end
		for (int a = 1; a < (1 << DEPTH_BITS); a++) begin
			fetch_address = BASE_ADDRESS + mem_address_t'(a);
			@(negedge CLK);
			assert (!fetch_miss) else begin
				$display("MISMATCH at %0t: prefetched line %h was lost", $time, fetch_address);
				$display("tests failed");
				$fatal(1);
			end
		end

		// Same index with a new tag evicts the old line, and back again
		fetch_and_expect_miss(ALIAS_ADDRESS);
		hold_until_hit();
		fetch_and_expect_miss(BASE_ADDRESS);
		hold_until_hit();
		fetch_address = CHANGED_ADDRESS;
		hold_until_hit();
		fetch_address = BASE_ADDRESS; // Look away so the stale copy is not fetched

		// The block is cached again, so CHANGED_ADDRESS holds a stale copy now
		change_word(CHANGED_ADDRESS, ~model_mem[CHANGED_ADDRESS]);
		@(negedge CLK);
		invalidate = 1'b1;
		@(negedge CLK);
		invalidate = 1'b0;
		await_invalidation();
		fetch_and_expect_miss(CHANGED_ADDRESS);
		hold_until_hit();

		// Random traffic against a randomly busy arbiter
		random_busy = 1'b1;
		repeat (RANDOM_FETCHES) begin
			rand_word = $random(seed);
			fetch_address = mem_address_t'(rand_word) & ADDRESS_MASK;
			hold_until_hit();
		end
		random_busy = 1'b0;
		mem_busy = 1'b0;

		@(negedge CLK);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
common/cpu_mem_pkg.sv
common/icache_pkg.sv
common/mem_rd_if.sv
icache/bram.sv
icache/cpu_instruction_cache.sv
verilog/memory_read_port.sv
verilog/fetch_subsystem_top.sv
sim/tb_fetch_subsystem.sv

//--- verilog/fetch_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction fetch side: cache in front of the arbitrated memory
module fetch_subsystem_top #(
	parameter int CACHE_DEPTH_BITS = icache_pkg::DEFAULT_DEPTH_BITS
) (
	input logic CLK,
	input logic RSTb,
	input cpu_mem_pkg::mem_address_t fetch_address,
	output cpu_mem_pkg::mem_data_t instruction,
	output logic fetch_miss, // Instruction not valid yet, keep the address
	input logic invalidate,
	output logic invalidation_done,
	input logic mem_busy, // Other masters hold the memory
	input logic load_en,
	input cpu_mem_pkg::mem_address_t load_address,
	input cpu_mem_pkg::mem_data_t load_data
);

	mem_rd_if u_mem_rd ();

	cpu_instruction_cache #(
		.CACHE_DEPTH_BITS(CACHE_DEPTH_BITS)
	) u_icache (
		.CLK(CLK),
		.RSTb(RSTb),
		.request_address(fetch_address),
		.instruction(instruction),
		.cache_miss(fetch_miss),
		.invalidate_cache(invalidate),
		.invalidation_done(invalidation_done),
		.mem(u_mem_rd.cache)
	);

	memory_read_port u_memory (
		.CLK(CLK),
		.RSTb(RSTb),
		.busy(mem_busy),
		.load_en(load_en),
		.load_address(load_address),
		.load_data(load_data),
		.mem(u_mem_rd.memory)
	);

endmodule

`default_nettype wire

//--- verilog/memory_read_port.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction memory behind an arbiter. Other traffic shows up as busy, and
// a taken request comes back READ_LATENCY cycles later with its own address
module memory_read_port (
	input logic CLK,
	input logic RSTb,
	input logic busy, // Arbiter is serving someone else this cycle
	input logic load_en,
	input cpu_mem_pkg::mem_address_t load_address,
	input cpu_mem_pkg::mem_data_t load_data,
	mem_rd_if.memory mem
);
	import cpu_mem_pkg::*;

	mem_data_t mem_array [1 << ADDRESS_BITS];

	logic accept;
	logic s1_valid; // Stage 1 holds the taken request
	mem_address_t s1_address;
	logic s2_valid; // Stage 2 holds the word read for it
	mem_address_t s2_address;
	mem_data_t s2_data;

	assign accept = mem.rd_req && !busy;

	// Load port writes take effect on the next edge
	always_ff @(posedge CLK) begin
		if (load_en) begin
			mem_array[load_address] <= load_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= accept;
			s2_valid <= s1_valid;
		end
	end

	// Address and data ride along without reset
	always_ff @(posedge CLK) begin
		s1_address <= mem.address;
		s2_address <= s1_address;
		s2_data <= mem_array[s1_address];
	end

	assign mem.success = s2_valid;
	assign mem.returned_address = s2_address;
	assign mem.data = s2_data;

	// Every success answers a request taken exactly READ_LATENCY cycles before
	assert property (@(posedge CLK) disable iff (!RSTb)
		mem.success |-> $past(accept, READ_LATENCY));

endmodule

`default_nettype wire
